// ==== src/conv_settings.svh ====
`ifndef CONV_SETTINGS_SVH
`define CONV_SETTINGS_SVH

// kernel geometry, the datapath is written for a 3x3 window
`define CONV_K      3

`define CONV_PIX_W  8   // one unsigned pixel
`define CONV_WT_W   4   // one unsigned weight
`define CONV_ROW_W  12  // three weights of one kernel row
`define CONV_PSUM_W 16  // 9 * 255 * 15 = 34425 needs 16 bits

// command payload, three pixels or a weight row or a bias
`define CONV_DATA_W 24

`endif

// ==== src/conv_pkg.sv ====
`default_nettype none

package conv_pkg;

  // command opcodes carried with cmd_valid
  typedef enum logic [1:0] {
    CMD_WEIGHT = 2'd0,  // shift one kernel row into the column
    CMD_BIAS   = 2'd1,  // load bias register
    CMD_NEWROW = 2'd2,  // restart window fill
    CMD_PIXEL  = 2'd3   // one column of three image rows
  } cmd_e;

  // controller FSM
  typedef enum logic [1:0] {
    ST_LOAD = 2'd0,  // kernel incomplete
    ST_FILL = 2'd1,  // window and pipe still filling
    ST_RUN  = 2'd2   // every pixel yields a result
  } ctrl_state_e;

endpackage

`default_nettype wire

// ==== src/conv_stream_if.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "conv_settings.svh"

interface conv_stream_if;

  logic                    pix_en;  // one-cycle pixel strobe
  logic                    wt_en;   // one-cycle weight strobe
  logic [`CONV_DATA_W-1:0] pix;     // rows 0..2, low byte is row 0
  logic [`CONV_ROW_W-1:0]  wt_row;  // weight row entering element 0
  logic [`CONV_PSUM_W-1:0] bias;    // seed for element 0 psum
  logic [`CONV_PSUM_W-1:0] psum;    // bottom of the column

  modport ctrl (
    output pix_en, wt_en, pix, wt_row, bias,
    input  psum
  );

  modport column (
    input  pix_en, wt_en, pix, wt_row, bias,
    output psum
  );

endinterface

`default_nettype wire

// ==== src/tap_shift_reg.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "conv_settings.svh"

module tap_shift_reg (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   en,    // shift strobe
  input  wire [`CONV_PIX_W-1:0] din,   // incoming pixel
  output logic [`CONV_PIX_W-1:0] tap0, // newest
  output logic [`CONV_PIX_W-1:0] tap1,
  output logic [`CONV_PIX_W-1:0] tap2  // oldest
);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tap0 <= '0;
      tap1 <= '0;
      tap2 <= '0;
    end else if (en) begin
      tap0 <= din;   // new sample at the head
      tap1 <= tap0;
      tap2 <= tap1;  // tap1 ages into the last slot
    end
  end

endmodule

`default_nettype wire

// ==== src/conv_pe.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "conv_settings.svh"

module conv_pe (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     pix_en,    // pixel strobe, shifts taps and updates psum
  input  wire                     wt_en,     // weight strobe, shifts weight row
  input  wire [`CONV_PIX_W-1:0]   pix_in,    // pixel of this element's row
  input  wire [`CONV_ROW_W-1:0]   filt_in,   // weight row from above
  input  wire [`CONV_PSUM_W-1:0]  psum_in,   // partial sum from above
  output logic [`CONV_ROW_W-1:0]  filt_out,  // held weight row, also goes below
  output logic [`CONV_PSUM_W-1:0] psum_out   // registered partial sum
);

  logic [`CONV_PIX_W-1:0] tap0, tap1, tap2;  // window before the edge
  logic [`CONV_PIX_W-1:0] nxt0, nxt1, nxt2;  // window after the edge
  logic [`CONV_PIX_W+`CONV_WT_W-1:0] prod0, prod1, prod2;  // 8x4 products
  logic [`CONV_PSUM_W-1:0] psum_nxt;

  tap_shift_reg u_taps (
    .clk   (clk),
    .rst_n (rst_n),
    .en    (pix_en),
    .din   (pix_in),
    .tap0  (tap0),
    .tap1  (tap1),
    .tap2  (tap2)
  );

  // same shift as u_taps, so this strobe's pixel is already in the window
  assign nxt0 = pix_en ? pix_in : tap0;
  assign nxt1 = pix_en ? tap0   : tap1;
  assign nxt2 = pix_en ? tap1   : tap2;

  assign prod0 = nxt0 * filt_out[`CONV_WT_W-1:0];               // w[0], newest
  assign prod1 = nxt1 * filt_out[2*`CONV_WT_W-1:`CONV_WT_W];
  assign prod2 = nxt2 * filt_out[3*`CONV_WT_W-1:2*`CONV_WT_W];  // w[2], oldest

  assign psum_nxt = psum_in + prod0 + prod1 + prod2;  // widened to 16 bits

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      filt_out <= '0;
      psum_out <= '0;
    end else begin
      if (wt_en)  filt_out <= filt_in;   // weights move one element down
      if (pix_en) psum_out <= psum_nxt;
    end
  end

endmodule

`default_nettype wire

// ==== src/pe_column.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "conv_settings.svh"

module pe_column (
  input  wire           clk,
  input  wire           rst_n,
  conv_stream_if.column link
);

  logic [`CONV_PIX_W-1:0]  row1_d1;           // row 1, one strobe late
  logic [`CONV_PIX_W-1:0]  row2_d1, row2_d2;  // row 2, two strobes late
  logic [`CONV_ROW_W-1:0]  filt_01, filt_12;  // weight chain
  logic [`CONV_PSUM_W-1:0] psum_01, psum_12;  // partial sum chain

  // skew so each element sees the column its upstream psum belongs to
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      row1_d1 <= '0;
      row2_d1 <= '0;
      row2_d2 <= '0;
    end else if (link.pix_en) begin
      row1_d1 <= link.pix[2*`CONV_PIX_W-1:`CONV_PIX_W];
      row2_d1 <= link.pix[3*`CONV_PIX_W-1:2*`CONV_PIX_W];
      row2_d2 <= row2_d1;
    end
  end

  conv_pe u_pe0 (  // kernel row 0, first in the chain
    .clk (clk), .rst_n (rst_n), .pix_en (link.pix_en), .wt_en (link.wt_en),
    .pix_in   (link.pix[`CONV_PIX_W-1:0]),
    .filt_in  (link.wt_row),
    .psum_in  (link.bias),  // bias seeds the sum
    .filt_out (filt_01),
    .psum_out (psum_01)
  );

  conv_pe u_pe1 (
    .clk (clk), .rst_n (rst_n), .pix_en (link.pix_en), .wt_en (link.wt_en),
    .pix_in (row1_d1), .filt_in (filt_01), .psum_in (psum_01),
    .filt_out (filt_12),
    .psum_out (psum_12)
  );

  conv_pe u_pe2 (  // kernel row 2, end of chain
    .clk (clk), .rst_n (rst_n), .pix_en (link.pix_en), .wt_en (link.wt_en),
    .pix_in (row2_d2), .filt_in (filt_12), .psum_in (psum_12),
    .filt_out (),           // nothing below the last element
    .psum_out (link.psum)   // full 3x3 sum
  );

endmodule

`default_nettype wire

// ==== src/conv_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "conv_settings.svh"

module conv_ctrl (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     cmd_valid,  // single-cycle command strobe
  input  wire conv_pkg::cmd_e     cmd,
  input  wire [`CONV_DATA_W-1:0]  cmd_data,
  conv_stream_if.ctrl             link,
  output logic                    out_valid,  // one cycle per result
  output logic [`CONV_PSUM_W-1:0] out_data
);

  localparam logic [1:0] K_ROWS    = 2'(`CONV_K);      // rows in a full kernel
  localparam logic [2:0] FILL_FULL = 3'(`CONV_K + 1);  // pixels before first result

  conv_pkg::ctrl_state_e   state;
  logic [1:0]              wt_cnt;    // rows loaded, saturates at 3
  logic [2:0]              fill_cnt;  // pixels since restart, saturates at 4
  logic                    v1, v2;    // result valid pipe
  logic [`CONV_PSUM_W-1:0] out_hold;  // last result, held between strobes

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= conv_pkg::ST_LOAD;
      wt_cnt      <= '0;
      fill_cnt    <= '0;
      v1          <= 1'b0;
      v2          <= 1'b0;
      out_hold    <= '0;
      link.pix_en <= 1'b0;
      link.wt_en  <= 1'b0;
      link.pix    <= '0;
      link.wt_row <= '0;
      link.bias   <= '0;  // bias resets to 0
    end else begin
      link.pix_en <= 1'b0;  // strobes last one cycle
      link.wt_en  <= 1'b0;
      v1          <= 1'b0;
      v2          <= v1;
      if (v2) out_hold <= link.psum;  // capture as the result is shown
      if (cmd_valid) begin
        case (cmd)
          conv_pkg::CMD_WEIGHT: begin
            link.wt_en  <= 1'b1;
            link.wt_row <= cmd_data[`CONV_ROW_W-1:0];
            if (wt_cnt >= K_ROWS - 2'd1) begin  // kernel complete or refreshed
              wt_cnt   <= K_ROWS;
              fill_cnt <= '0;
              state    <= conv_pkg::ST_FILL;
            end else begin
              wt_cnt <= wt_cnt + 2'd1;
            end
          end
          conv_pkg::CMD_BIAS: link.bias <= cmd_data[`CONV_PSUM_W-1:0];
          conv_pkg::CMD_NEWROW: begin
            fill_cnt <= '0;                                // window starts over
            if (wt_cnt == K_ROWS) state <= conv_pkg::ST_FILL;
          end
          conv_pkg::CMD_PIXEL: begin
            if (state != conv_pkg::ST_LOAD) begin        // dropped until kernel loaded
              link.pix_en <= 1'b1;
              link.pix    <= cmd_data;
              v1          <= (state == conv_pkg::ST_RUN);  // k >= 4 qualifies
              if (fill_cnt == FILL_FULL - 3'd1) state <= conv_pkg::ST_RUN;
              if (fill_cnt != FILL_FULL) fill_cnt <= fill_cnt + 3'd1;
            end
          end
        endcase
      end
    end
  end

  // psum of element 2 settles the cycle v2 is high
  assign out_valid = v2;
  assign out_data  = v2 ? link.psum : out_hold;

endmodule

`default_nettype wire

// ==== src/conv_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "conv_settings.svh"

module conv_top (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     cmd_valid,  // single-cycle strobe, no back-pressure
  input  wire conv_pkg::cmd_e     cmd,
  input  wire [`CONV_DATA_W-1:0]  cmd_data,
  output logic                    out_valid,  // 2 cycles after a qualifying pixel
  output logic [`CONV_PSUM_W-1:0] out_data
);

  conv_stream_if link ();  // ctrl to column

  conv_ctrl u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .cmd_data  (cmd_data),
    .link      (link.ctrl),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

  // systolic column, one element per kernel row
  pe_column u_column (
    .clk   (clk),
    .rst_n (rst_n),
    .link  (link.column)
  );

endmodule

`default_nettype wire

// ==== tb/tb_clkgen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
  output logic clk  // free-running testbench clock
);

  initial begin
    clk = 1'b0;  // known level before the first edge
  end

  always begin
    #2 clk = ~clk;  // half of the 4 ns period
  end

endmodule

`default_nettype wire

// ==== tb/conv_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_asserts (
  input wire       clk,
  input wire       rst_n,
  input wire       cmd_valid,
  input wire [1:0] cmd,        // raw opcode bits
  input wire       out_valid,
  input wire       pix_en,     // strobes inside the link
  input wire       wt_en,
  input wire [1:0] state       // controller FSM state
);

  // strobes cleared by the synchronous reset
  a_reset_quiet: assert property (@(posedge clk) !rst_n |=> (!out_valid && !pix_en && !wt_en))
    else $error("strobe high during reset");

  // each result lines up with its pixel command
  a_valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> $past(cmd_valid && (cmd == conv_pkg::CMD_PIXEL), 2))
    else $error("out_valid without a pixel two cycles before");

  // no pixel reaches the column before the kernel is complete
  a_no_pix_in_load: assert property (@(posedge clk) disable iff (!rst_n)
    pix_en |-> (state != conv_pkg::ST_LOAD))
    else $error("pix_en while kernel incomplete");

endmodule

`default_nettype wire

// ==== tb/conv_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "conv_settings.svh"

module conv_tb;

  logic                    clk;
  logic                    rst_n;
  logic                    cmd_valid;
  conv_pkg::cmd_e          cmd;
  logic [`CONV_DATA_W-1:0] cmd_data;
  logic                    out_valid;
  logic [`CONV_PSUM_W-1:0] out_data;

  // command table
  logic                    tab_v[$];
  conv_pkg::cmd_e          tab_c[$];
  logic [`CONV_DATA_W-1:0] tab_d[$];

  // expected results and the negedge count they are due at
  int exp_val[$];
  int exp_cyc[$];
  int held_val;                // last expected result, out_data holds it

  // reference model state
  int          krow[3];        // kernel rows with krow[0] loaded last
  int          m_wcnt;
  int          m_bias;
  int          hist_pix[$];    // columns since restart
  int          hist_bias[$];   // bias in force when each column entered
  int unsigned seed;
  int          neg_cnt;
  int          cyc_cnt;
  int          limit;

  tb_clkgen u_clk (.clk(clk));

  conv_top UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .cmd_data  (cmd_data),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

  bind conv_top conv_asserts u_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .out_valid (out_valid),
    .pix_en    (link.pix_en),
    .wt_en     (link.wt_en),
    .state     (u_ctrl.state)
  );

  function automatic int next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;  // classic LCG constants
    return int'(seed[30:7]);                   // 24 bits for one pixel column
  endfunction

  task automatic add_cmd(input logic v, input conv_pkg::cmd_e c, input int d);
    tab_v.push_back(v);
    tab_c.push_back(c);
    tab_d.push_back(d[`CONV_DATA_W-1:0]);
  endtask

  task automatic add_idle(input int n);
    for (int i = 0; i < n; i++) add_cmd(1'b0, conv_pkg::CMD_PIXEL, 0);
  endtask

  task automatic add_pixels(input int n, input int gap);
    for (int i = 0; i < n; i++) begin
      add_cmd(1'b1, conv_pkg::CMD_PIXEL, next_rand());
      if (gap > 0 && i % 2 == 1) add_idle(gap);  // idle gap after every second pixel
    end
  endtask

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("TESTS FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "run stopped");
    end
  endtask

  // one table entry through the model with a result queued once the window is full
  task automatic model_cmd(input logic v, input conv_pkg::cmd_e c, input int d);
    int k;
    int sum;
    int px;
    if (!v) return;
    case (c)
      conv_pkg::CMD_WEIGHT: begin
        krow[2] = krow[1];  // earlier rows move down the column
        krow[1] = krow[0];
        krow[0] = d & 12'hfff;
        if (m_wcnt >= 2) begin
          m_wcnt = 3;
          hist_pix.delete();  // window restarts on kernel completion
          hist_bias.delete();
        end else begin
          m_wcnt++;
        end
      end
      conv_pkg::CMD_BIAS: m_bias = d & 16'hffff;
      conv_pkg::CMD_NEWROW: begin
        hist_pix.delete();
        hist_bias.delete();
      end
      default: begin
        if (m_wcnt == 3) begin  // ignored while weights incomplete
          hist_pix.push_back(d);
          hist_bias.push_back(m_bias);
          k = hist_pix.size() - 1;
          if (k >= 4) begin
            sum = hist_bias[k-2];
            for (int r = 0; r < 3; r++) begin
              for (int j = 0; j < 3; j++) begin
                px = (hist_pix[k-2-j] >> (8 * r)) & 8'hff;
                sum += ((krow[r] >> (4 * j)) & 4'hf) * px;
              end
            end
            exp_val.push_back(sum & 16'hffff);
            exp_cyc.push_back(neg_cnt + 3);  // seen at the third falling edge
          end
        end
      end
    endcase
  endtask

  // result monitor on the falling edge away from the drive edge
  always @(negedge clk) begin
    neg_cnt = neg_cnt + 1;
    if (rst_n && out_valid) begin
      if (exp_val.size() == 0) begin
        fail_now("out_valid seen with no result expected");
      end else begin
        held_val = exp_val.pop_front();
        check_value("out_data", int'(out_data), held_val);
        check_value("out_valid_cycle", neg_cnt, exp_cyc.pop_front());
      end
    end else if (rst_n) begin
      check_value("out_data", int'(out_data), held_val);  // held between results
    end
  end

  always @(posedge clk) begin
    cyc_cnt = cyc_cnt + 1;
    if (limit > 0 && cyc_cnt > limit) fail_now("timeout, results did not drain");
  end

  initial begin
    rst_n     = 1'b0;
    cmd_valid = 1'b0;
    cmd       = conv_pkg::CMD_WEIGHT;
    cmd_data  = '0;
    seed      = 4786;
    m_wcnt    = 0;
    m_bias    = 0;
    held_val  = 0;
    neg_cnt   = 0;
    cyc_cnt   = 0;
    limit     = 0;
    for (int i = 0; i < 3; i++) krow[i] = 0;

    // 1 pixels before the kernel is loaded
    add_pixels(3, 0);
    add_cmd(1'b1, conv_pkg::CMD_WEIGHT, 12'h321);
    add_pixels(2, 0);
    add_idle(2);
    // 2 full kernel, bias, 10 back-to-back columns
    add_cmd(1'b1, conv_pkg::CMD_WEIGHT, 12'h5a7);
    add_cmd(1'b1, conv_pkg::CMD_WEIGHT, 12'hf09);
    add_cmd(1'b1, conv_pkg::CMD_BIAS, 16'h0123);
    add_pixels(10, 0);
    add_idle(3);
    // 3 same kernel with idle gaps
    add_cmd(1'b1, conv_pkg::CMD_NEWROW, 0);
    add_pixels(10, 2);
    add_idle(3);
    // 4 restart in the middle of a row
    add_cmd(1'b1, conv_pkg::CMD_NEWROW, 0);
    add_pixels(6, 0);
    add_cmd(1'b1, conv_pkg::CMD_NEWROW, 0);
    add_pixels(6, 0);
    add_idle(3);
    // 5 new kernel, new bias between rows, then all-max
    add_cmd(1'b1, conv_pkg::CMD_WEIGHT, 12'h1e3);
    add_cmd(1'b1, conv_pkg::CMD_WEIGHT, 12'h7c2);
    add_cmd(1'b1, conv_pkg::CMD_WEIGHT, 12'hb48);
    add_cmd(1'b1, conv_pkg::CMD_BIAS, 16'h0040);
    add_cmd(1'b1, conv_pkg::CMD_NEWROW, 0);
    add_pixels(8, 0);
    add_cmd(1'b1, conv_pkg::CMD_WEIGHT, 12'hfff);
    add_cmd(1'b1, conv_pkg::CMD_WEIGHT, 12'hfff);
    add_cmd(1'b1, conv_pkg::CMD_WEIGHT, 12'hfff);
    add_cmd(1'b1, conv_pkg::CMD_BIAS, 16'd100);  // 34425 + 100 still fits
    for (int i = 0; i < 6; i++) add_cmd(1'b1, conv_pkg::CMD_PIXEL, 24'hffffff);
    add_idle(2);

    limit = tab_v.size() + 20;  // every entry takes one cycle

    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    for (int i = 0; i < tab_v.size(); i++) begin
      @(posedge clk);
      cmd_valid <= tab_v[i];
      cmd       <= tab_c[i];
      cmd_data  <= tab_d[i];
      model_cmd(tab_v[i], tab_c[i], int'(tab_d[i]));
    end
    @(posedge clk);
    cmd_valid <= 1'b0;

    while (exp_val.size() != 0) @(posedge clk);  // watchdog bounds this
    repeat (4) @(posedge clk);                   // catch late strays

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+src
src/conv_pkg.sv
src/conv_stream_if.sv
src/tap_shift_reg.sv
src/conv_pe.sv
src/pe_column.sv
src/conv_ctrl.sv
src/conv_top.sv
tb/tb_clkgen.sv
tb/conv_asserts.sv
tb/conv_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the conv engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module conv_tb -f filelist.f -o conv_sim
status=$?
if [ $status -ne 0 ]; then
  echo "compile failed"
  exit $status
fi

./obj_dir/conv_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed"
  exit $status
fi

exit 0
